/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS = --lint-only --timing -Wall
TOP       = mau_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Test passed
FAIL_MSG  = Test failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not finish"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* flist.f */
+incdir+hdl
hdl/mau_pkg.sv
hdl/mau_arbiter.sv
hdl/mau_track_fifo.sv
hdl/mau_wb_issue.sv
hdl/mau_line_collect.sv
hdl/mau_top.sv
verification/mau_wb_slave.sv
verification/mau_sva.sv
verification/mau_tb.sv

/* hdl/mau_arbiter.sv */
`timescale 1ns/10ps

`include "mau_macros.svh"

module mau_arbiter import mau_pkg::*; (
	input  logic                        wb_clk_i,
	input  logic                        rst_n,

	// Instruction cache request
	input  logic                        l1i_req_val_i,
	input  logic [`CORE_ADDR_WIDTH-1:0] l1i_req_addr_i,
	output logic                        l1i_req_ready_o,

	// Data cache request
	input  logic                        l1d_req_val_i,
	input  logic                        l1d_req_we_i,
	input  logic                        l1d_req_nc_i,
	input  logic [`CORE_ADDR_WIDTH-1:0] l1d_req_addr_i,
	input  logic [`CORE_DATA_WIDTH-1:0] l1d_req_wdata_i,
	input  logic [`CORE_BE_WIDTH-1:0]   l1d_req_be_i,
	output logic                        l1d_req_ready_o,

	// Towards the issue stage
	input  logic                        issue_ready_i,
	output logic                        arb_valid_o,
	output mau_req_t                    arb_req_o
);

	logic     slot_free;
	logic     load;
	logic     arb_valid_q;
	mau_req_t arb_req_q;
	mau_req_t sel_req;

	// No request is taken while in reset
	// Register can take a new entry when empty or being drained
	assign slot_free = rst_n & (~arb_valid_q | issue_ready_i);

	// Data cache wins when both are pending
	assign l1d_req_ready_o = slot_free & l1d_req_val_i;
	assign l1i_req_ready_o = slot_free & l1i_req_val_i & ~l1d_req_val_i;
	assign load            = l1d_req_ready_o | l1i_req_ready_o;

	always_comb begin
		if (l1d_req_val_i) begin
			sel_req.src   = SRC_D;
			sel_req.we    = l1d_req_we_i;
			sel_req.nc    = l1d_req_nc_i;
			sel_req.addr  = l1d_req_addr_i;
			sel_req.wdata = l1d_req_wdata_i;
			sel_req.be    = l1d_req_be_i;
		end else begin
			// Instruction fetches are always cached line reads
			sel_req.src   = SRC_I;
			sel_req.we    = 1'b0;
			sel_req.nc    = 1'b0;
			sel_req.addr  = l1i_req_addr_i;
			sel_req.wdata = '0;
			sel_req.be    = '1;
		end
	end

	always_ff @(posedge wb_clk_i or negedge rst_n) begin
		if (!rst_n) begin
			arb_valid_q <= 1'b0;
		end else if (load) begin
			arb_valid_q <= 1'b1;
		end else if (arb_valid_q && issue_ready_i) begin
			arb_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (load) begin
			arb_req_q <= sel_req;
		end
	end

	assign arb_valid_o = arb_valid_q;
	assign arb_req_o   = arb_req_q;

endmodule

/* hdl/mau_line_collect.sv */
`timescale 1ns/10ps

`include "mau_macros.svh"

module mau_line_collect import mau_pkg::*; (
	input  logic                        wb_clk_i,
	input  logic                        rst_n,

	// Wishbone response side
	input  logic                        wb_ack_i,
	input  logic [`CORE_DATA_WIDTH-1:0] wb_dat_i,

	// Tracker head
	input  mau_track_t                  head_i,
	output logic                        pop_o,

	// Cache responses
	output logic                        l1i_resp_val_o,
	output logic                        l1d_resp_val_o,
	output logic                        l1d_resp_we_o,
	output logic                        l1d_resp_nc_o,
	output logic [`L1_LINE_SIZE-1:0]    resp_line_o
);

	localparam int WORD = `CORE_DATA_WIDTH;
	localparam int LINE = `L1_LINE_SIZE;

	logic [MAU_CNT_WIDTH-1:0] ack_cnt_q;
	logic                     last_ack;
	logic [LINE-1:0]          line_q;
	logic                     resp_i_q;
	logic                     resp_d_q;
	logic                     resp_we_q;
	logic                     resp_nc_q;

	// ----------------------------------------
	// Acknowledgement counting
	// ----------------------------------------

	// Acks return in issue order so the head always owns the current one
	assign last_ack = wb_ack_i & (ack_cnt_q == head_i.cnt);
	assign pop_o    = last_ack;

	always_ff @(posedge wb_clk_i or negedge rst_n) begin
		if (!rst_n) begin
			ack_cnt_q <= '0;
		end else if (last_ack) begin
			ack_cnt_q <= '0;
		end else if (wb_ack_i) begin
			ack_cnt_q <= ack_cnt_q + 1'b1;
		end
	end

	// Words enter at the top, so the first beat ends in the lowest word
	always_ff @(posedge wb_clk_i) begin
		if (wb_ack_i) begin
			line_q <= {wb_dat_i, line_q[LINE-1:WORD]};
		end
	end

	// ----------------------------------------
	// Response pulse
	// ----------------------------------------

	always_ff @(posedge wb_clk_i or negedge rst_n) begin
		if (!rst_n) begin
			resp_i_q  <= 1'b0;
			resp_d_q  <= 1'b0;
			resp_we_q <= 1'b0;
			resp_nc_q <= 1'b0;
		end else begin
			resp_i_q <= last_ack & (head_i.src == SRC_I);
			resp_d_q <= last_ack & (head_i.src == SRC_D);
			if (last_ack) begin
				resp_we_q <= head_i.we;
				resp_nc_q <= head_i.nc;
			end
		end
	end

	assign l1i_resp_val_o = resp_i_q;
	assign l1d_resp_val_o = resp_d_q;
	assign l1d_resp_we_o  = resp_we_q;
	assign l1d_resp_nc_o  = resp_nc_q;
	assign resp_line_o    = line_q;

endmodule

/* hdl/mau_macros.svh */
`ifndef MAU_MACROS_SVH
`define MAU_MACROS_SVH

// ----------------------------------------
// Core bus widths
// ----------------------------------------

`define CORE_ADDR_WIDTH 32
`define CORE_DATA_WIDTH 32
`define CORE_BE_WIDTH   4

// ----------------------------------------
// Cache line and tracker sizing
// ----------------------------------------

`define L1_LINE_SIZE    128
`define MAU_BEATS       4
`define MAU_TRACK_DEPTH 2

`endif

/* hdl/mau_pkg.sv */
`include "mau_macros.svh"

package mau_pkg;

	// Width of a beat counter, one less than the beats per line fits
	localparam int MAU_CNT_WIDTH = $clog2(`MAU_BEATS);

	// Requesting cache
	typedef enum logic {
		SRC_I = 1'b0,
		SRC_D = 1'b1
	} mau_src_e;

	// ----------------------------------------
	// Request selected by the arbiter
	// ----------------------------------------

	typedef struct packed {
		mau_src_e                    src;
		logic                        we;
		logic                        nc;
		logic [`CORE_ADDR_WIDTH-1:0] addr;
		logic [`CORE_DATA_WIDTH-1:0] wdata;
		logic [`CORE_BE_WIDTH-1:0]   be;
	} mau_req_t;

	// ----------------------------------------
	// Outstanding transaction record
	// ----------------------------------------

	typedef struct packed {
		mau_src_e                 src;
		logic                     we;
		logic                     nc;
		// Beats expected minus one
		logic [MAU_CNT_WIDTH-1:0] cnt;
	} mau_track_t;

endpackage

/* hdl/mau_top.sv */
`timescale 1ns/10ps

`include "mau_macros.svh"

module mau_top import mau_pkg::*; (
	input  logic                        wb_clk_i,
	input  logic                        rst_n,

	// Instruction cache
	input  logic                        l1i_req_val_i,
	input  logic [`CORE_ADDR_WIDTH-1:0] l1i_req_addr_i,
	output logic                        l1i_req_ready_o,
	output logic                        l1i_resp_val_o,

	// Data cache
	input  logic                        l1d_req_val_i,
	input  logic                        l1d_req_we_i,
	input  logic                        l1d_req_nc_i,
	input  logic [`CORE_ADDR_WIDTH-1:0] l1d_req_addr_i,
	input  logic [`CORE_DATA_WIDTH-1:0] l1d_req_wdata_i,
	input  logic [`CORE_BE_WIDTH-1:0]   l1d_req_be_i,
	output logic                        l1d_req_ready_o,
	output logic                        l1d_resp_val_o,
	output logic                        l1d_resp_we_o,
	output logic                        l1d_resp_nc_o,

	// Shared response line
	output logic [`L1_LINE_SIZE-1:0]    resp_line_o,

	// Wishbone B4 pipelined master
	input  logic [`CORE_DATA_WIDTH-1:0] wb_dat_i,
	input  logic                        wb_ack_i,
	input  logic                        wb_stall_i,
	output logic [`CORE_ADDR_WIDTH-1:0] wb_adr_o,
	output logic [`CORE_DATA_WIDTH-1:0] wb_dat_o,
	output logic [`CORE_BE_WIDTH-1:0]   wb_sel_o,
	output logic                        wb_we_o,
	output logic                        wb_stb_o,
	output logic                        wb_cyc_o
);

	logic       arb_valid;
	mau_req_t   arb_req;
	logic       issue_ready;
	logic       track_push;
	mau_track_t track_rec;
	logic       track_full;
	logic       track_pop;
	mau_track_t track_head;

	// ----------------------------------------
	// Stage one
	// ----------------------------------------

	mau_arbiter u_arbiter (
		.wb_clk_i        (wb_clk_i),
		.rst_n           (rst_n),
		.l1i_req_val_i   (l1i_req_val_i),
		.l1i_req_addr_i  (l1i_req_addr_i),
		.l1i_req_ready_o (l1i_req_ready_o),
		.l1d_req_val_i   (l1d_req_val_i),
		.l1d_req_we_i    (l1d_req_we_i),
		.l1d_req_nc_i    (l1d_req_nc_i),
		.l1d_req_addr_i  (l1d_req_addr_i),
		.l1d_req_wdata_i (l1d_req_wdata_i),
		.l1d_req_be_i    (l1d_req_be_i),
		.l1d_req_ready_o (l1d_req_ready_o),
		.issue_ready_i   (issue_ready),
		.arb_valid_o     (arb_valid),
		.arb_req_o       (arb_req)
	);

	// ----------------------------------------
	// Stage two and tracker
	// ----------------------------------------

	mau_wb_issue u_wb_issue (
		.wb_clk_i      (wb_clk_i),
		.rst_n         (rst_n),
		.arb_valid_i   (arb_valid),
		.arb_req_i     (arb_req),
		.issue_ready_o (issue_ready),
		.track_full_i  (track_full),
		.track_push_o  (track_push),
		.track_rec_o   (track_rec),
		.wb_stall_i    (wb_stall_i),
		.wb_adr_o      (wb_adr_o),
		.wb_dat_o      (wb_dat_o),
		.wb_sel_o      (wb_sel_o),
		.wb_we_o       (wb_we_o),
		.wb_stb_o      (wb_stb_o)
	);

	// Cycle stays up while any transaction is outstanding
	mau_track_fifo u_track_fifo (
		.wb_clk_i   (wb_clk_i),
		.rst_n      (rst_n),
		.push_i     (track_push),
		.push_rec_i (track_rec),
		.pop_i      (track_pop),
		.full_o     (track_full),
		.empty_o    (),
		.busy_o     (wb_cyc_o),
		.head_o     (track_head)
	);

	// ----------------------------------------
	// Stage three
	// ----------------------------------------

	mau_line_collect u_line_collect (
		.wb_clk_i       (wb_clk_i),
		.rst_n          (rst_n),
		.wb_ack_i       (wb_ack_i),
		.wb_dat_i       (wb_dat_i),
		.head_i         (track_head),
		.pop_o          (track_pop),
		.l1i_resp_val_o (l1i_resp_val_o),
		.l1d_resp_val_o (l1d_resp_val_o),
		.l1d_resp_we_o  (l1d_resp_we_o),
		.l1d_resp_nc_o  (l1d_resp_nc_o),
		.resp_line_o    (resp_line_o)
	);

endmodule

/* hdl/mau_track_fifo.sv */
`timescale 1ns/10ps

`include "mau_macros.svh"

module mau_track_fifo import mau_pkg::*; (
	input  logic       wb_clk_i,
	input  logic       rst_n,
	input  logic       push_i,
	input  mau_track_t push_rec_i,
	input  logic       pop_i,
	output logic       full_o,
	output logic       empty_o,
	output logic       busy_o,
	output mau_track_t head_o
);

	localparam int DEPTH = `MAU_TRACK_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	mau_track_t       mem_q [DEPTH];
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [CNT_W-1:0] count_q;
	logic [CNT_W-1:0] count_nxt;
	logic             do_push;
	logic             do_pop;
	logic             busy_q;

	assign full_o  = (count_q == CNT_W'(DEPTH));
	assign empty_o = (count_q == '0);
	assign do_push = push_i & ~full_o;
	assign do_pop  = pop_i & ~empty_o;

	// Simultaneous push and pop keep the occupancy
	always_comb begin
		case ({do_push, do_pop})
			2'b10:   count_nxt = count_q + 1'b1;
			2'b01:   count_nxt = count_q - 1'b1;
			default: count_nxt = count_q;
		endcase
	end

	always_ff @(posedge wb_clk_i or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
			busy_q   <= 1'b0;
		end else begin
			if (do_push) begin
				wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
			end
			if (do_pop) begin
				rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
			end
			count_q <= count_nxt;
			// Drives the bus cycle signal
			busy_q  <= (count_nxt != '0);
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (do_push) begin
			mem_q[wr_ptr_q] <= push_rec_i;
		end
	end

	assign head_o = mem_q[rd_ptr_q];
	assign busy_o = busy_q;

endmodule

/* hdl/mau_wb_issue.sv */
`timescale 1ns/10ps

`include "mau_macros.svh"

module mau_wb_issue import mau_pkg::*; (
	input  logic                        wb_clk_i,
	input  logic                        rst_n,

	// From the arbiter
	input  logic                        arb_valid_i,
	input  mau_req_t                    arb_req_i,
	output logic                        issue_ready_o,

	// Tracker push side
	input  logic                        track_full_i,
	output logic                        track_push_o,
	output mau_track_t                  track_rec_o,

	// Wishbone request side
	input  logic                        wb_stall_i,
	output logic [`CORE_ADDR_WIDTH-1:0] wb_adr_o,
	output logic [`CORE_DATA_WIDTH-1:0] wb_dat_o,
	output logic [`CORE_BE_WIDTH-1:0]   wb_sel_o,
	output logic                        wb_we_o,
	output logic                        wb_stb_o
);

	localparam int WORD_BYTES = `CORE_DATA_WIDTH / 8;
	localparam int WORD_OFS   = $clog2(WORD_BYTES);
	localparam int LINE_OFS   = $clog2(`L1_LINE_SIZE / 8);

	typedef enum logic {
		ST_IDLE = 1'b0,
		ST_REQ  = 1'b1
	} issue_state_e;

	issue_state_e                state_q;
	logic [MAU_CNT_WIDTH-1:0]    beat_cnt_q;
	logic [`CORE_ADDR_WIDTH-1:0] adr_q;
	logic [`CORE_DATA_WIDTH-1:0] dat_q;
	logic [`CORE_BE_WIDTH-1:0]   sel_q;
	logic                        we_q;
	logic                        accept;
	logic                        is_line;
	logic                        beat_taken;
	logic                        last_beat;
	logic [`CORE_ADDR_WIDTH-1:0] start_adr;

	assign issue_ready_o = (state_q == ST_IDLE) & ~track_full_i;
	assign accept        = arb_valid_i & issue_ready_o;
	assign is_line       = ~arb_req_i.we & ~arb_req_i.nc;

	// Lines start at the line boundary, single beats at the word
	assign start_adr = is_line ?
		{arb_req_i.addr[`CORE_ADDR_WIDTH-1:LINE_OFS], {LINE_OFS{1'b0}}} :
		{arb_req_i.addr[`CORE_ADDR_WIDTH-1:WORD_OFS], {WORD_OFS{1'b0}}};

	// ----------------------------------------
	// Tracking record
	// ----------------------------------------

	assign track_push_o    = accept;
	assign track_rec_o.src = arb_req_i.src;
	assign track_rec_o.we  = arb_req_i.we;
	assign track_rec_o.nc  = arb_req_i.nc;
	assign track_rec_o.cnt = is_line ? MAU_CNT_WIDTH'(`MAU_BEATS - 1) : '0;

	// ----------------------------------------
	// Beat walker
	// ----------------------------------------

	// A beat is sampled by the slave whenever strobe is up and not stalled
	assign beat_taken = (state_q == ST_REQ) & ~wb_stall_i;
	assign last_beat  = beat_taken & (beat_cnt_q == '0);

	always_ff @(posedge wb_clk_i or negedge rst_n) begin
		if (!rst_n) begin
			state_q    <= ST_IDLE;
			beat_cnt_q <= '0;
			we_q       <= 1'b0;
		end else if (accept) begin
			state_q    <= ST_REQ;
			beat_cnt_q <= track_rec_o.cnt;
			we_q       <= arb_req_i.we;
		end else if (last_beat) begin
			state_q    <= ST_IDLE;
			we_q       <= 1'b0;
		end else if (beat_taken) begin
			beat_cnt_q <= beat_cnt_q - 1'b1;
		end
	end

	// Stall leaves address and data untouched
	always_ff @(posedge wb_clk_i) begin
		if (accept) begin
			adr_q <= start_adr;
			dat_q <= arb_req_i.wdata;
			sel_q <= arb_req_i.be;
		end else if (beat_taken && !last_beat) begin
			adr_q <= adr_q + `CORE_ADDR_WIDTH'(WORD_BYTES);
		end
	end

	assign wb_adr_o = adr_q;
	assign wb_dat_o = dat_q;
	assign wb_sel_o = sel_q;
	assign wb_we_o  = we_q;
	assign wb_stb_o = (state_q == ST_REQ);

endmodule

/* verification/mau_sva.sv */
`timescale 1ns/10ps

`include "mau_macros.svh"

module mau_sva (
	input logic                        wb_clk_i,
	input logic                        rst_n,
	input logic                        wb_cyc_o,
	input logic                        wb_stb_o,
	input logic                        wb_stall_i,
	input logic                        wb_we_o,
	input logic [`CORE_ADDR_WIDTH-1:0] wb_adr_o,
	input logic                        l1i_req_val_i,
	input logic                        l1i_req_ready_o,
	input logic                        l1d_req_val_i,
	input logic                        l1d_req_ready_o
);

	int unsigned fail_count = 0;

	// Strobe only inside a bus cycle
	stb_in_cyc: assert property (@(posedge wb_clk_i) disable iff (!rst_n)
		wb_stb_o |-> wb_cyc_o)
		else begin
			fail_count++;
			$error("wb_stb_o high while wb_cyc_o is low");
		end

	// A stalled beat keeps its address and direction
	stall_hold: assert property (@(posedge wb_clk_i) disable iff (!rst_n)
		(wb_stb_o && wb_stall_i) |=> ($stable(wb_adr_o) && $stable(wb_we_o)))
		else begin
			fail_count++;
			$error("wb_adr_o or wb_we_o changed under stall");
		end

	no_hs_in_reset: assert property (@(posedge wb_clk_i)
		!rst_n |-> !(l1i_req_val_i && l1i_req_ready_o) && !(l1d_req_val_i && l1d_req_ready_o))
		else begin
			fail_count++;
			$error("request handshake during reset");
		end

endmodule

bind mau_top mau_sva u_mau_sva (
	.wb_clk_i        (wb_clk_i),
	.rst_n           (rst_n),
	.wb_cyc_o        (wb_cyc_o),
	.wb_stb_o        (wb_stb_o),
	.wb_stall_i      (wb_stall_i),
	.wb_we_o         (wb_we_o),
	.wb_adr_o        (wb_adr_o),
	.l1i_req_val_i   (l1i_req_val_i),
	.l1i_req_ready_o (l1i_req_ready_o),
	.l1d_req_val_i   (l1d_req_val_i),
	.l1d_req_ready_o (l1d_req_ready_o)
);

/* verification/mau_tb.sv */
`timescale 1ns/10ps

`include "mau_macros.svh"

module mau_tb import mau_pkg::*; ();

	localparam int          HALF           = 10;
	localparam int          TIMEOUT_CYCLES = 500;
	localparam logic [31:0] SEED           = 32'd35740;

	logic                        wb_clk_i;
	logic                        rst_n;
	logic                        l1i_req_val_i;
	logic [`CORE_ADDR_WIDTH-1:0] l1i_req_addr_i;
	logic                        l1i_req_ready_o;
	logic                        l1i_resp_val_o;
	logic                        l1d_req_val_i;
	logic                        l1d_req_we_i;
	logic                        l1d_req_nc_i;
	logic [`CORE_ADDR_WIDTH-1:0] l1d_req_addr_i;
	logic [`CORE_DATA_WIDTH-1:0] l1d_req_wdata_i;
	logic [`CORE_BE_WIDTH-1:0]   l1d_req_be_i;
	logic                        l1d_req_ready_o;
	logic                        l1d_resp_val_o;
	logic                        l1d_resp_we_o;
	logic                        l1d_resp_nc_o;
	logic [`L1_LINE_SIZE-1:0]    resp_line_o;
	logic [`CORE_DATA_WIDTH-1:0] wb_dat_i;
	logic                        wb_ack_i;
	logic                        wb_stall_i;
	logic [`CORE_ADDR_WIDTH-1:0] wb_adr_o;
	logic [`CORE_DATA_WIDTH-1:0] wb_dat_o;
	logic [`CORE_BE_WIDTH-1:0]   wb_sel_o;
	logic                        wb_we_o;
	logic                        wb_stb_o;
	logic                        wb_cyc_o;

	// Reference model and bookkeeping
	logic [31:0] shadow [256];
	mau_req_t    i_exp [$];
	mau_req_t    d_exp [$];
	logic [31:0] rng_i;
	logic [31:0] rng_d;
	int          cycle;
	int          errors;
	int          timeouts;
	int          n_i_acc;
	int          n_d_acc;
	int          n_i_resp;
	int          n_d_resp;
	int          i_resp_cycle;
	int          d_resp_cycle;

	mau_top u_mau_top (.*);

	mau_wb_slave #(.SEED(SEED ^ 32'h1234_5678)) u_wb_slave (
		.wb_clk_i   (wb_clk_i),
		.rst_n      (rst_n),
		.wb_cyc_i   (wb_cyc_o),
		.wb_stb_i   (wb_stb_o),
		.wb_we_i    (wb_we_o),
		.wb_adr_i   (wb_adr_o),
		.wb_dat_i   (wb_dat_o),
		.wb_sel_i   (wb_sel_o),
		.wb_dat_o   (wb_dat_i),
		.wb_ack_o   (wb_ack_i),
		.wb_stall_o (wb_stall_i)
	);

	always #(HALF) wb_clk_i = ~wb_clk_i;

	always @(posedge wb_clk_i) begin
		cycle <= cycle + 1;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] fill_word(input int k);
		logic [7:0] a;
		a = 8'(k);
		return {a ^ 8'hA5, ~a, a, a + 8'h3C};
	endfunction

	task automatic check_value(input string name, input logic [31:0] act, input logic [31:0] exp);
		if (act !== exp) begin
			errors++;
			$display("Fail %s: got 0x%08h, expected 0x%08h", name, act, exp);
		end
	endtask

	task automatic report_timeout(input string what);
		timeouts++;
		$display("Timeout while waiting for %s", what);
	endtask

	// ----------------------------------------
	// Request drivers entered on a falling edge
	// ----------------------------------------

	task automatic send_ireq(input logic [31:0] addr);
		mau_req_t rec;
		int       waited;
		logic     taken;
		rec = '0;
		rec.src = SRC_I;
		rec.addr = addr;
		l1i_req_addr_i = addr;
		l1i_req_val_i = 1'b1;
		waited = 0;
		taken = 1'b0;
		while (!taken && waited < TIMEOUT_CYCLES) begin
			// Ready is settled halfway through the low phase
			#(HALF / 2);
			taken = l1i_req_ready_o;
			@(negedge wb_clk_i);
			waited++;
		end
		l1i_req_val_i = 1'b0;
		if (taken) begin
			i_exp.push_back(rec);
			n_i_acc++;
		end else begin
			report_timeout("the instruction request handshake");
		end
	endtask

	task automatic send_dreq(input logic we, input logic nc, input logic [31:0] addr,
			input logic [31:0] wdata, input logic [3:0] be);
		mau_req_t rec;
		int       waited;
		logic     taken;
		rec = '{src: SRC_D, we: we, nc: nc, addr: addr, wdata: wdata, be: be};
		l1d_req_we_i = we;
		l1d_req_nc_i = nc;
		l1d_req_addr_i = addr;
		l1d_req_wdata_i = wdata;
		l1d_req_be_i = be;
		l1d_req_val_i = 1'b1;
		waited = 0;
		taken = 1'b0;
		while (!taken && waited < TIMEOUT_CYCLES) begin
			#(HALF / 2);
			taken = l1d_req_ready_o;
			@(negedge wb_clk_i);
			waited++;
		end
		l1d_req_val_i = 1'b0;
		if (taken) begin
			d_exp.push_back(rec);
			n_d_acc++;
		end else begin
			report_timeout("the data request handshake");
		end
	endtask

	task automatic wait_drained();
		int waited;
		waited = 0;
		@(posedge wb_clk_i);
		while ((i_exp.size() != 0 || d_exp.size() != 0) && waited < TIMEOUT_CYCLES) begin
			@(posedge wb_clk_i);
			waited++;
		end
		if (i_exp.size() != 0 || d_exp.size() != 0) begin
			report_timeout("the outstanding responses");
		end
		@(negedge wb_clk_i);
	endtask

	// ----------------------------------------
	// Response checking against the shadow memory
	// ----------------------------------------

	task automatic check_line(input logic [31:0] addr);
		for (int w = 0; w < 4; w++) begin
			check_value($sformatf("resp_line_o[word %0d]", w), resp_line_o[32*w +: 32],
				shadow[{addr[9:4], 2'(w)}]);
		end
	endtask

	task automatic check_iresp();
		mau_req_t exp;
		n_i_resp++;
		i_resp_cycle = cycle;
		if (i_exp.size() == 0) begin
			errors++;
			$display("Instruction response arrived with no request outstanding");
		end else begin
			exp = i_exp.pop_front();
			check_line(exp.addr);
		end
	endtask

	task automatic check_dresp();
		mau_req_t exp;
		n_d_resp++;
		d_resp_cycle = cycle;
		if (d_exp.size() == 0) begin
			errors++;
			$display("Data response arrived with no request outstanding");
		end else begin
			exp = d_exp.pop_front();
			check_value("l1d_resp_we_o", 32'(l1d_resp_we_o), 32'(exp.we));
			check_value("l1d_resp_nc_o", 32'(l1d_resp_nc_o), 32'(exp.nc));
			if (exp.we) begin
				// Write is committed once its response is seen
				for (int b = 0; b < 4; b++) begin
					if (exp.be[b]) begin
						shadow[exp.addr[9:2]][8*b +: 8] = exp.wdata[8*b +: 8];
					end
				end
			end else if (exp.nc) begin
				check_value("resp_line_o[word 3]", resp_line_o[127:96], shadow[exp.addr[9:2]]);
			end else begin
				check_line(exp.addr);
			end
		end
	endtask

	always @(negedge wb_clk_i) begin
		if (rst_n && l1i_resp_val_o) begin
			check_iresp();
		end
		if (rst_n && l1d_resp_val_o) begin
			check_dresp();
		end
	end

	// ----------------------------------------
	// Random traffic per port
	// ----------------------------------------

	task automatic run_random_i(input int count);
		for (int n = 0; n < count; n++) begin
			if (timeouts != 0) begin
				break;
			end
			rng_i = xorshift32(rng_i);
			repeat (int'(rng_i[17:16])) @(negedge wb_clk_i);
			send_ireq({23'd0, rng_i[8:0]});
		end
	endtask

	task automatic run_random_d(input int count);
		logic [1:0]  kind;
		logic [31:0] addr;
		logic [3:0]  be;
		for (int n = 0; n < count; n++) begin
			if (timeouts != 0) begin
				break;
			end
			rng_d = xorshift32(rng_d);
			kind = 2'(rng_d[7:0] % 3);
			addr = {22'd0, rng_d[25:18], 2'd0};
			be = rng_d[11:8];
			repeat (int'(rng_d[17:16])) @(negedge wb_clk_i);
			rng_d = xorshift32(rng_d);
			case (kind)
				2'd0:    send_dreq(1'b1, 1'b0, {22'd0, 1'b1, addr[8:2], 2'd0}, rng_d, be);
				2'd1:    send_dreq(1'b0, 1'b1, addr, '0, '0);
				default: send_dreq(1'b0, 1'b0, {addr[31:4], 4'd0}, '0, '0);
			endcase
		end
	endtask

	initial begin
		logic [31:0] addr;
		wb_clk_i = 1'b0;
		rst_n = 1'b0;
		// Requests held up through reset must not be taken
		l1i_req_val_i = 1'b1;
		l1i_req_addr_i = '0;
		l1d_req_val_i = 1'b1;
		l1d_req_we_i = 1'b0;
		l1d_req_nc_i = 1'b0;
		l1d_req_addr_i = '0;
		l1d_req_wdata_i = '0;
		l1d_req_be_i = '0;
		rng_i = SEED;
		rng_d = ~SEED;
		cycle = 0;
		errors = 0;
		timeouts = 0;
		n_i_acc = 0;
		n_d_acc = 0;
		n_i_resp = 0;
		n_d_resp = 0;
		i_resp_cycle = 0;
		d_resp_cycle = 0;
		for (int k = 0; k < 256; k++) begin
			shadow[k] = fill_word(k);
		end
		repeat (10) @(posedge wb_clk_i);
		@(negedge wb_clk_i);
		check_value("l1i_req_ready_o", 32'(l1i_req_ready_o), 32'd0);
		check_value("l1d_req_ready_o", 32'(l1d_req_ready_o), 32'd0);
		l1i_req_val_i = 1'b0;
		l1d_req_val_i = 1'b0;
		rst_n = 1'b1;
		@(negedge wb_clk_i);
		check_value("wb_cyc_o", 32'(wb_cyc_o), 32'd0);
		check_value("wb_stb_o", 32'(wb_stb_o), 32'd0);
		check_value("wb_we_o", 32'(wb_we_o), 32'd0);

		// Instruction line reads
		repeat (4) begin
			rng_i = xorshift32(rng_i);
			send_ireq({23'd0, rng_i[8:0]});
		end
		wait_drained();

		// Data uncached read and line read
		rng_d = xorshift32(rng_d);
		send_dreq(1'b0, 1'b1, {22'd0, rng_d[9:2], 2'd0}, '0, '0);
		send_dreq(1'b0, 1'b0, {22'd0, rng_d[19:14], 4'd0}, '0, '0);
		wait_drained();

		// Partial write followed by a read of the same word
		rng_d = xorshift32(rng_d);
		addr = {22'd0, 1'b1, rng_d[6:0], 2'd0};
		send_dreq(1'b1, 1'b0, addr, xorshift32(rng_d), rng_d[11:8] | 4'b0001);
		send_dreq(1'b0, 1'b1, addr, '0, '0);
		wait_drained();

		// Both caches at once where the data side wins
		rng_i = xorshift32(rng_i);
		rng_d = xorshift32(rng_d);
		fork
			send_dreq(1'b0, 1'b0, {22'd0, rng_d[9:4], 4'd0}, '0, '0);
			send_ireq({23'd0, rng_i[8:4], 4'd0});
		join
		wait_drained();
		check_value("l1d response first", 32'(d_resp_cycle < i_resp_cycle), 32'd1);

		// Mixed random traffic under stall and ack delay
		fork
			run_random_i(100);
			run_random_d(200);
		join
		wait_drained();
		check_value("l1i response count", n_i_resp, n_i_acc);
		check_value("l1d response count", n_d_resp, n_d_acc);

		errors = errors + int'(u_mau_top.u_mau_sva.fail_count);
		$display("Errors: %0d mismatches, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* verification/mau_wb_slave.sv */
`timescale 1ns/10ps

`include "mau_macros.svh"

module mau_wb_slave #(
	parameter logic [31:0] SEED = 32'd1
) (
	input  logic                        wb_clk_i,
	input  logic                        rst_n,
	input  logic                        wb_cyc_i,
	input  logic                        wb_stb_i,
	input  logic                        wb_we_i,
	input  logic [`CORE_ADDR_WIDTH-1:0] wb_adr_i,
	input  logic [`CORE_DATA_WIDTH-1:0] wb_dat_i,
	input  logic [`CORE_BE_WIDTH-1:0]   wb_sel_i,
	output logic [`CORE_DATA_WIDTH-1:0] wb_dat_o,
	output logic                        wb_ack_o,
	output logic                        wb_stall_o
);

	logic [31:0] mem [256];
	logic [31:0] rdata_q [$];
	int          due_q [$];
	logic [31:0] rng;
	logic [7:0]  idx;
	int          now;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Every byte depends on the full word index
	initial begin
		for (int k = 0; k < 256; k++) begin
			idx = 8'(k);
			mem[k] = {idx ^ 8'hA5, ~idx, idx, idx + 8'h3C};
		end
	end

	always @(posedge wb_clk_i or negedge rst_n) begin
		if (!rst_n) begin
			wb_ack_o   <= 1'b0;
			wb_stall_o <= 1'b0;
			wb_dat_o   <= '0;
			rng = SEED;
			now = 0;
			rdata_q.delete();
			due_q.delete();
		end else begin
			now = now + 1;
			// Head was acknowledged during the cycle just ended
			if (wb_ack_o) begin
				void'(rdata_q.pop_front());
				void'(due_q.pop_front());
			end
			if (wb_cyc_i && wb_stb_i && !wb_stall_o) begin
				idx = wb_adr_i[9:2];
				if (wb_we_i) begin
					for (int b = 0; b < 4; b++) begin
						if (wb_sel_i[b]) begin
							mem[idx][8*b +: 8] = wb_dat_i[8*b +: 8];
						end
					end
				end
				rng = xorshift32(rng);
				rdata_q.push_back(mem[idx]);
				due_q.push_back(now + int'(rng[1:0]));
			end
			rng = xorshift32(rng);
			wb_stall_o <= (rng[2:0] < 3'd2);
			// Acks leave strictly in beat order
			if (due_q.size() > 0 && due_q[0] <= now) begin
				wb_ack_o <= 1'b1;
				wb_dat_o <= rdata_q[0];
			end else begin
				wb_ack_o <= 1'b0;
			end
		end
	end

endmodule
